/* rv_pkg.sv */
package rv_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;  // data and address width
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int PC_STEP    = 4;   // one word per fetch

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;  // addi x0,x0,0

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        OPC_IMM   = 7'b0010011,
        OPC_REG   = 7'b0110011,
        OPC_LOAD  = 7'b0000011,
        OPC_STORE = 7'b0100011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;  // sw uses the same code
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl/sra, split by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // sub, sra, srai

    // alu ops, shared by register and immediate forms
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

endpackage

/* rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,  // rs2 or immediate
    output logic [rv_pkg::XLEN-1:0] y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shifts use low five bits

    //////////////////////////////////////////////////////////////////////
    // operations
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: y = a + b;
            rv_pkg::ALU_SUB: y = a - b;
            rv_pkg::ALU_SLL: y = a << shamt;
            rv_pkg::ALU_SRL: y = a >> shamt;
            // keep the sign bit
            rv_pkg::ALU_SRA: y = $unsigned($signed(a) >>> shamt);
            rv_pkg::ALU_XOR: y = a ^ b;
            rv_pkg::ALU_OR:  y = a | b;
            rv_pkg::ALU_AND: y = a & b;
            default:         y = '0;
        endcase
    end

endmodule

/* rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,      // load-use interlock from decode
    input  logic [rv_pkg::XLEN-1:0] imem_data,  // comb read of imem at pc
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    output logic [rv_pkg::XLEN-1:0] id_instr    // IF/ID register
);

    logic [rv_pkg::XLEN-1:0] pc;

    //////////////////////////////////////////////////////////////////////
    // program counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + rv_pkg::XLEN'(rv_pkg::PC_STEP);  // no branches, always sequential
        end
    end

    assign imem_addr = pc;

    // IF/ID latches the memory word directly
    always_ff @(posedge clk) begin
        if (rst) begin
            id_instr <= rv_pkg::NOP_INSTR;
        end else if (!stall) begin
            id_instr <= imem_data;
        end  // stalled: hold for re-decode
    end

    // word fetch only
    pc_aligned_a: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

/* rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_pkg::XLEN-1:0]       id_instr,
    // writeback port into the register file
    input  logic                          wb_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic                          stall,
    // ID/EX register
    output rv_pkg::alu_op_e               ex_alu_op,
    output logic                          ex_sel_imm,
    output logic [rv_pkg::XLEN-1:0]       ex_imm,
    output logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic [rv_pkg::XLEN-1:0]       ex_rs1_val,
    output logic [rv_pkg::XLEN-1:0]       ex_rs2_val,
    output logic                          ex_reg_we,
    output logic                          ex_load,
    output logic                          ex_store
);

    rv_pkg::opcode_e                 opcode;
    logic [2:0]                      funct3;
    logic [6:0]                      funct7;
    logic [rv_pkg::REG_ADDR_W-1:0]   rd, rs1, rs2;
    logic [rv_pkg::XLEN-1:0]         imm_i, imm_sh, imm_s;
    logic [rv_pkg::XLEN-1:0]         imm;
    rv_pkg::alu_op_e                 alu_op;
    logic                            valid, is_load, is_store, sel_imm, use_rs2;
    logic                            reg_we;
    logic [rv_pkg::XLEN-1:0]         regs [rv_pkg::NUM_REGS];
    logic [rv_pkg::XLEN-1:0]         rs1_val, rs2_val;

    //////////////////////////////////////////////////////////////////////
    // fields and immediates
    //////////////////////////////////////////////////////////////////////

    assign opcode = rv_pkg::opcode_e'(id_instr[6:0]);
    assign rd     = id_instr[11:7];
    assign funct3 = id_instr[14:12];
    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];
    assign funct7 = id_instr[31:25];

    assign imm_i  = {{20{id_instr[31]}}, id_instr[31:20]};
    assign imm_sh = {27'b0, id_instr[24:20]};  // shamt only
    assign imm_s  = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};

    //////////////////////////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op   = rv_pkg::ALU_ADD;  // also address calc for lw/sw
        imm      = imm_i;
        sel_imm  = 1'b0;
        use_rs2  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        valid    = 1'b0;  // anything unmatched becomes a bubble
        case (opcode)
            rv_pkg::OPC_REG: begin
                use_rs2 = 1'b1;
                valid   = (funct7 == 7'b0);
                case (funct3)
                    rv_pkg::F3_ADD_SUB: begin
                        alu_op = (funct7 == rv_pkg::FUNCT7_ALT) ? rv_pkg::ALU_SUB
                                                                : rv_pkg::ALU_ADD;
                        valid  = valid || (funct7 == rv_pkg::FUNCT7_ALT);
                    end
                    rv_pkg::F3_SR: begin
                        alu_op = (funct7 == rv_pkg::FUNCT7_ALT) ? rv_pkg::ALU_SRA
                                                                : rv_pkg::ALU_SRL;
                        valid  = valid || (funct7 == rv_pkg::FUNCT7_ALT);
                    end
                    rv_pkg::F3_SLL: alu_op = rv_pkg::ALU_SLL;
                    rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::F3_OR:  alu_op = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND: alu_op = rv_pkg::ALU_AND;
                    default:        valid  = 1'b0;  // slt/sltu not kept
                endcase
            end
            rv_pkg::OPC_IMM: begin
                sel_imm = 1'b1;
                valid   = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD_SUB: alu_op = rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLL: begin
                        alu_op = rv_pkg::ALU_SLL;
                        imm    = imm_sh;
                        valid  = (funct7 == 7'b0);
                    end
                    rv_pkg::F3_SR: begin
                        alu_op = (funct7 == rv_pkg::FUNCT7_ALT) ? rv_pkg::ALU_SRA
                                                                : rv_pkg::ALU_SRL;
                        imm    = imm_sh;
                        valid  = (funct7 == 7'b0) || (funct7 == rv_pkg::FUNCT7_ALT);
                    end
                    rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::F3_OR:  alu_op = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND: alu_op = rv_pkg::ALU_AND;
                    default:        valid  = 1'b0;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                sel_imm = 1'b1;
                is_load = 1'b1;
                valid   = (funct3 == rv_pkg::F3_LW);  // word only
            end
            rv_pkg::OPC_STORE: begin
                sel_imm  = 1'b1;
                imm      = imm_s;
                use_rs2  = 1'b1;  // store data
                is_store = 1'b1;
                valid    = (funct3 == rv_pkg::F3_LW);
            end
            default: valid = 1'b0;
        endcase
    end

    // x0 never written, so nothing downstream checks rd
    assign reg_we = valid && !is_store && (rd != '0);

    //////////////////////////////////////////////////////////////////////
    // register file, write-through from writeback
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_val = (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

    // load in EX feeding this instruction, data not there yet
    assign stall = ex_load && ex_reg_we &&
                   ((ex_rd == rs1) || (use_rs2 && ex_rd == rs2));

    //////////////////////////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            ex_reg_we <= 1'b0;  // bubble
            ex_load   <= 1'b0;
            ex_store  <= 1'b0;
        end else begin
            ex_reg_we <= reg_we;
            ex_load   <= valid && is_load;
            ex_store  <= valid && is_store;
        end
    end

    // payload, harmless under a bubble
    always_ff @(posedge clk) begin
        ex_alu_op  <= alu_op;
        ex_sel_imm <= sel_imm;
        ex_imm     <= imm;
        ex_rs1     <= rs1;
        ex_rs2     <= rs2;
        ex_rd      <= rd;
        ex_rs1_val <= rs1_val;
        ex_rs2_val <= rs2_val;
    end

    // the bubble clears ex_load, so the interlock lasts one cycle
    stall_once_a: assert property (@(posedge clk) disable iff (rst) stall |=> !stall);

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  logic                          clk,
    input  logic                          rst,
    // ID/EX
    input  rv_pkg::alu_op_e               ex_alu_op,
    input  logic                          ex_sel_imm,
    input  logic [rv_pkg::XLEN-1:0]       ex_imm,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [rv_pkg::XLEN-1:0]       ex_rs1_val,
    input  logic [rv_pkg::XLEN-1:0]       ex_rs2_val,
    input  logic                          ex_reg_we,
    input  logic                          ex_load,
    input  logic                          ex_store,
    // data memory, driven from EX/MEM
    input  logic [rv_pkg::XLEN-1:0]       dmem_rdata,
    output logic [rv_pkg::XLEN-1:0]       dmem_addr,
    output logic [rv_pkg::XLEN-1:0]       dmem_wdata,
    output logic                          dmem_wen,
    output logic                          dmem_ren,
    // writeback
    output logic                          wb_we,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rv_pkg::XLEN-1:0]       wb_data
);

    logic [rv_pkg::XLEN-1:0]       src_a, src_b, alu_b, alu_y;
    logic [rv_pkg::XLEN-1:0]       mem_alu_y, mem_wdata;
    logic [rv_pkg::REG_ADDR_W-1:0] mem_rd;
    logic                          mem_we, mem_load, mem_store;
    logic [rv_pkg::XLEN-1:0]       wb_alu_y, wb_rdata;
    logic                          wb_load;
    logic                          mem_fwd_ok;

    //////////////////////////////////////////////////////////////////////
    // forwarding
    //////////////////////////////////////////////////////////////////////

    // a load in EX/MEM has no data yet, the interlock covers that case
    assign mem_fwd_ok = mem_we && !mem_load;

    assign src_a = (mem_fwd_ok && mem_rd == ex_rs1) ? mem_alu_y :
                   (wb_we && wb_rd == ex_rs1)       ? wb_data   : ex_rs1_val;
    assign src_b = (mem_fwd_ok && mem_rd == ex_rs2) ? mem_alu_y :
                   (wb_we && wb_rd == ex_rs2)       ? wb_data   : ex_rs2_val;

    assign alu_b = ex_sel_imm ? ex_imm : src_b;

    rv_alu alu_i (
        .op (ex_alu_op),
        .a  (src_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    //////////////////////////////////////////////////////////////////////
    // EX/MEM and MEM/WB
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_we    <= 1'b0;
            mem_load  <= 1'b0;
            mem_store <= 1'b0;
            wb_we     <= 1'b0;
            wb_load   <= 1'b0;
        end else begin
            mem_we    <= ex_reg_we;
            mem_load  <= ex_load;
            mem_store <= ex_store;
            wb_we     <= mem_we;
            wb_load   <= mem_load;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_y <= alu_y;  // result or lw/sw address
        mem_wdata <= src_b;  // forwarded store data
        mem_rd    <= ex_rd;
        wb_alu_y  <= mem_alu_y;
        wb_rdata  <= dmem_rdata;
        wb_rd     <= mem_rd;
    end

    assign dmem_addr  = mem_alu_y;
    assign dmem_wdata = mem_wdata;
    assign dmem_wen   = mem_store;
    assign dmem_ren   = mem_load;

    assign wb_data = wb_load ? wb_rdata : wb_alu_y;

    // decode never marks one instruction as both
    dmem_excl_a: assert property (@(posedge clk) disable iff (rst) !(dmem_wen && dmem_ren));

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst,
    // instruction memory
    input  logic [rv_pkg::XLEN-1:0] imem_data,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    // data memory
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata,
    output logic [rv_pkg::XLEN-1:0] dmem_addr,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata,
    output logic                    dmem_wen,
    output logic                    dmem_ren
);

    logic [rv_pkg::XLEN-1:0]       id_instr;
    logic                          stall;
    rv_pkg::alu_op_e               ex_alu_op;
    logic                          ex_sel_imm;
    logic [rv_pkg::XLEN-1:0]       ex_imm;
    logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
    logic [rv_pkg::XLEN-1:0]       ex_rs1_val, ex_rs2_val;
    logic                          ex_reg_we, ex_load, ex_store;
    logic                          wb_we;
    logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [rv_pkg::XLEN-1:0]       wb_data;

    //////////////////////////////////////////////////////////////////////
    // pipeline stages
    //////////////////////////////////////////////////////////////////////

    rv_fetch fetch_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .id_instr  (id_instr)
    );

    rv_decode decode_i (
        .clk (clk), .rst (rst), .id_instr (id_instr),
        .wb_we (wb_we), .wb_rd (wb_rd), .wb_data (wb_data), .stall (stall),
        .ex_alu_op (ex_alu_op), .ex_sel_imm (ex_sel_imm), .ex_imm (ex_imm),
        .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2), .ex_rd (ex_rd),
        .ex_rs1_val (ex_rs1_val), .ex_rs2_val (ex_rs2_val),
        .ex_reg_we (ex_reg_we), .ex_load (ex_load), .ex_store (ex_store)
    );

    // execute, memory access and writeback select
    rv_execute execute_i (
        .clk (clk), .rst (rst),
        .ex_alu_op (ex_alu_op), .ex_sel_imm (ex_sel_imm), .ex_imm (ex_imm),
        .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2), .ex_rd (ex_rd),
        .ex_rs1_val (ex_rs1_val), .ex_rs2_val (ex_rs2_val),
        .ex_reg_we (ex_reg_we), .ex_load (ex_load), .ex_store (ex_store),
        .dmem_rdata (dmem_rdata), .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata),
        .dmem_wen (dmem_wen), .dmem_ren (dmem_ren),
        .wb_we (wb_we), .wb_rd (wb_rd), .wb_data (wb_data)
    );

endmodule

/* tb_rv_model.svh */
// expected data memory traffic, filled by run_model
logic [31:0] exp_store_addr [$];
logic [31:0] exp_store_data [$];
logic [31:0] exp_load_addr  [$];

// in-order ISA model over imem, registers and memory start at zero
task automatic run_model();
    logic [31:0] x [32];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] w, a, b, res, addr;
    logic [4:0]  sh;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic        alt, wr;
    foreach (x[k]) x[k] = '0;
    foreach (mem[k]) mem[k] = '0;
    for (int i = 0; i < NUM_INSTR; i++) begin
        w   = imem[i];
        opc = w[6:0];
        f3  = w[14:12];
        alt = w[30];                 // funct7 alt bit
        a   = x[w[19:15]];
        wr  = 1'b0;
        res = '0;
        if (opc == rv_pkg::OPC_LOAD) begin
            addr = a + {{20{w[31]}}, w[31:20]};
            exp_load_addr.push_back(addr);
            res = mem[addr[8:2]];
            wr  = 1'b1;
        end else if (opc == rv_pkg::OPC_STORE) begin
            addr = a + {{20{w[31]}}, w[31:25], w[11:7]};  // split S immediate
            exp_store_addr.push_back(addr);
            exp_store_data.push_back(x[w[24:20]]);
            mem[addr[8:2]] = x[w[24:20]];
        end else if (opc == rv_pkg::OPC_REG || opc == rv_pkg::OPC_IMM) begin
            b  = (opc == rv_pkg::OPC_REG) ? x[w[24:20]] : {{20{w[31]}}, w[31:20]};
            sh = b[4:0];
            wr = 1'b1;
            case (f3)
                rv_pkg::F3_ADD_SUB: res = (opc == rv_pkg::OPC_REG && alt) ? a - b : a + b;
                rv_pkg::F3_SLL:     res = a << sh;
                // arithmetic right shift built from the logical one plus sign fill
                rv_pkg::F3_SR: res = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh)
                                                                  : 32'h0);
                rv_pkg::F3_XOR:     res = a ^ b;
                rv_pkg::F3_OR:      res = a | b;
                default:            res = a & b;  // generator emits kept codes only
            endcase
        end
        if (wr && w[11:7] != 5'd0) begin
            x[w[11:7]] = res;  // x0 stays zero
        end
    end
endtask

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int CLK_PERIOD     = 100;
    localparam int PROG_LEN       = 64;               // random part
    localparam int NUM_DUMP       = 7;                // sw of x1..x7
    localparam int NUM_INSTR      = PROG_LEN + NUM_DUMP;
    localparam int MEM_WORDS      = 128;              // word index is addr[8:2]
    localparam int TIMEOUT_CYCLES = 2 * NUM_INSTR + 20;

    logic        clk, rst;
    logic [31:0] imem_data, imem_addr;
    logic [31:0] dmem_rdata, dmem_addr, dmem_wdata;
    logic        dmem_wen, dmem_ren;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] lfsr;
    logic [31:0] prev_pc;
    logic        running;  // monitor enable from the end of reset
    int          store_cnt, load_cnt;

    `include "tb_rv_model.svh"

    rv_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .imem_data  (imem_data),
        .imem_addr  (imem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .dmem_ren   (dmem_ren)
    );

    //////////////////////////////////////////////////////////////////////
    // memories with combinational read
    //////////////////////////////////////////////////////////////////////

    assign imem_data  = (imem_addr < MEM_WORDS * 4) ? imem[imem_addr[8:2]]
                                                    : rv_pkg::NOP_INSTR;  // past the end
    assign dmem_rdata = dmem[dmem_addr[8:2]];

    always @(posedge clk) begin
        if (dmem_wen) begin
            dmem[dmem_addr[8:2]] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // checks and random source
    //////////////////////////////////////////////////////////////////////

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("Regression failed");
            $fatal(1, "run stopped on first error");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s (at %0t ns)", why, $time);
        $display("Regression failed");
        $fatal(1, "run stopped on first error");
    endtask

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(1 + take_bits(3) % 7);  // x1..x7 only to crowd hazards
    endfunction

    function automatic logic [31:0] enc_reg(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_REG};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_store(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, rv_pkg::F3_LW, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    // one random alu instruction in register or immediate form
    function automatic logic [31:0] random_alu(input logic [4:0] rs1);
        logic        reg_form;
        logic [2:0]  sel;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd, rs2;
        logic [11:0] imm;
        reg_form = take_bits(1) != 0;
        sel      = 3'(take_bits(3));
        rd       = pick_reg();
        rs2      = pick_reg();
        imm      = 12'(take_bits(12));
        f7       = 7'b0;
        case (sel)
            3'd0: f3 = rv_pkg::F3_ADD_SUB;
            3'd1: begin
                f3 = rv_pkg::F3_ADD_SUB;
                f7 = rv_pkg::FUNCT7_ALT;  // sub in reg form and plain addi in imm form
            end
            3'd2: f3 = rv_pkg::F3_SLL;
            3'd3: f3 = rv_pkg::F3_SR;
            3'd4: begin
                f3 = rv_pkg::F3_SR;
                f7 = rv_pkg::FUNCT7_ALT;  // sra / srai
            end
            3'd5: f3 = rv_pkg::F3_XOR;
            3'd6: f3 = rv_pkg::F3_OR;
            default: f3 = rv_pkg::F3_AND;
        endcase
        if (reg_form) begin
            return enc_reg(f7, rs2, rs1, f3, rd);
        end else if (f3 == rv_pkg::F3_SLL || f3 == rv_pkg::F3_SR) begin
            return enc_imm({f7, imm[4:0]}, rs1, f3, rd, rv_pkg::OPC_IMM);  // shamt form
        end else begin
            return enc_imm(imm, rs1, f3, rd, rv_pkg::OPC_IMM);
        end
    endfunction

    task automatic build_program();
        int          i;
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [11:0] offs;
        i = 0;
        while (i < PROG_LEN) begin
            kind = 3'(take_bits(3));
            rd   = pick_reg();
            offs = 12'(take_bits(6) << 2);  // word aligned below 256
            if (kind <= 3'd1) begin
                imem[i] = enc_imm(offs, 5'd0, rv_pkg::F3_LW, rd, rv_pkg::OPC_LOAD);
                i++;
                if (i < PROG_LEN && take_bits(2) == 0) begin
                    imem[i] = random_alu(rd);  // consumer right behind the load
                    i++;
                end
            end else if (kind == 3'd2) begin
                imem[i] = enc_store(offs, rd, 5'd0);  // rd is the data source here
                i++;
            end else begin
                imem[i] = random_alu(pick_reg());
                i++;
            end
        end
        for (int k = 1; k <= NUM_DUMP; k++) begin
            imem[PROG_LEN + k - 1] = enc_store(12'(256 + 4 * (k - 1)), 5'(k), 5'd0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (running) begin
            check_eq((imem_addr == prev_pc) || (imem_addr == prev_pc + rv_pkg::PC_STEP),
                     32'd1, "imem_addr holds or steps");
            prev_pc = imem_addr;
            if (dmem_wen) begin
                if (store_cnt >= exp_store_addr.size()) begin
                    fail_run("a store appeared after the last expected one");
                end else begin
                    check_eq(dmem_addr, exp_store_addr[store_cnt], "store address");
                    check_eq(dmem_wdata, exp_store_data[store_cnt], "store data");
                    store_cnt++;
                end
            end
            if (dmem_ren) begin
                if (load_cnt >= exp_load_addr.size()) begin
                    fail_run("a load appeared after the last expected one");
                end else begin
                    check_eq(dmem_addr, exp_load_addr[load_cnt], "load address");
                    load_cnt++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired, the stores did not complete");
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst       = 1'b1;
        running   = 1'b0;
        store_cnt = 0;
        load_cnt  = 0;
        prev_pc   = '0;
        lfsr      = 32'h6991;
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k] = '0;
            dmem[k] = '0;
        end
        build_program();
        for (int k = NUM_INSTR; k < MEM_WORDS; k++) begin
            imem[k] = rv_pkg::NOP_INSTR;  // fill behind the dump
        end
        run_model();
        // 4 reset cycles and the first cycle out of reset
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            if (c == 3) begin
                rst     <= 1'b0;
                running = 1'b1;
            end
            @(negedge clk);
            check_eq(imem_addr, '0, "imem_addr around reset");
            check_eq(dmem_wen, 1'b0, "dmem_wen around reset");
            check_eq(dmem_ren, 1'b0, "dmem_ren around reset");
        end
        wait (store_cnt == exp_store_addr.size());
        repeat (4) @(posedge clk);  // room for any stray access
        check_eq(load_cnt, exp_load_addr.size(), "load count");
        $display("Regression passed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv
